// ==== spi_cfg.svh ====
//--------------------------------------------------------------------------
// Build-time sizing of the SPI minion subsystem: frame width, FIFO depths
// and the width of the RX credit counter. Include wherever a macro is read.
//--------------------------------------------------------------------------
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// Bits per SPI frame, top two bits are header
`define SPI_NBITS 8

// FIFO depths, powers of two
`define SPI_TX_DEPTH 4
`define SPI_RX_DEPTH 4

// Must hold the larger of the two depths
`define SPI_CREDIT_W 3

`endif

// ==== spi_pkg.sv ====
//--------------------------------------------------------------------------
// Shared types of the SPI minion subsystem. Referenced by scoped name
// (spi_pkg::name) from the RTL and the testbench.
//--------------------------------------------------------------------------
`include "spi_cfg.svh"

package spi_pkg;

  // One frame as shifted on the wire
  typedef logic [`SPI_NBITS-1:0] spi_word_t;

  // Frame without the two header bits, covered by parity
  typedef logic [`SPI_NBITS-3:0] spi_payload_t;

  // FIFO pointers carry one extra wrap bit
  typedef logic [$clog2(`SPI_TX_DEPTH):0] spi_tx_ptr_t;
  typedef logic [$clog2(`SPI_RX_DEPTH):0] spi_rx_ptr_t;

  typedef logic [`SPI_CREDIT_W-1:0] spi_credit_t;

endpackage

// ==== spi_sync.sv ====
//--------------------------------------------------------------------------
// Brings one asynchronous SPI pin into the clk domain and flags its edges.
// out follows the pin after two cycles, rise and fall one cycle later.
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module spi_sync #(
  parameter logic reset_level = 1'b0
) (
  input  logic clk,
  input  logic reset,
  input  logic pin,
  output logic out,
  output logic rise,
  output logic fall
);

  logic meta;
  logic out_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      meta  <= reset_level;
      out   <= reset_level;
      out_d <= reset_level;
      rise  <= 1'b0;
      fall  <= 1'b0;
    end else begin
      meta  <= pin;
      out   <= meta;
      out_d <= out;
      // Edge pulses registered off the settled copy
      rise  <= out & ~out_d;
      fall  <= ~out & out_d;
    end
  end

endmodule

// ==== spi_msg_if.sv ====
//--------------------------------------------------------------------------
// Pull and push message bundle between the SPI minion and the adapter.
// The minion requests a TX word on pull and hands over an RX word on push.
//--------------------------------------------------------------------------
`timescale 1ns/1ns

interface spi_msg_if;

  // Pull side, word presented in the same cycle as pull_en
  logic               pull_en;
  spi_pkg::spi_word_t pull_msg;

  // Push side, word and parity valid with push_en
  logic               push_en;
  spi_pkg::spi_word_t push_msg;
  logic               parity;

  modport minion (
    output pull_en, push_en, push_msg, parity,
    input  pull_msg
  );

  modport adapter (
    input  pull_en, push_en, push_msg, parity,
    output pull_msg
  );

endinterface

// ==== spi_minion.sv ====
//--------------------------------------------------------------------------
// SPI mode-0 minion. Samples mosi on sclk rise and updates miso on sclk
// fall, one frame per chip-select window, MSB first.
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "spi_cfg.svh"

module spi_minion (
  input  logic      clk,
  input  logic      reset,
  input  logic      cs,
  input  logic      sclk,
  input  logic      mosi,
  output logic      miso,
  spi_msg_if.minion msg
);

  logic cs_s;
  logic cs_rise;
  logic cs_fall;
  logic sclk_rise;
  logic sclk_fall;
  logic mosi_s;

  spi_pkg::spi_word_t    in_shreg;
  spi_pkg::spi_word_t    out_shreg;
  spi_pkg::spi_payload_t payload;

  // cs idles high
  spi_sync #(.reset_level(1'b1)) cs_sync (
    .clk(clk), .reset(reset), .pin(cs),
    .out(cs_s), .rise(cs_rise), .fall(cs_fall)
  );

  spi_sync #(.reset_level(1'b0)) sclk_sync (
    .clk(clk), .reset(reset), .pin(sclk),
    .out(), .rise(sclk_rise), .fall(sclk_fall)
  );

  spi_sync #(.reset_level(1'b0)) mosi_sync (
    .clk(clk), .reset(reset), .pin(mosi),
    .out(mosi_s), .rise(), .fall()
  );

  // Receive path
  always_ff @(posedge clk) begin
    if (!cs_s && sclk_rise)
      in_shreg <= {in_shreg[`SPI_NBITS-2:0], mosi_s};
  end

  // Transmit path, cleared so miso idles low
  always_ff @(posedge clk) begin
    if (reset)
      out_shreg <= '0;
    else if (msg.pull_en)
      out_shreg <= msg.pull_msg;
    else if (!cs_s && sclk_fall)
      out_shreg <= {out_shreg[`SPI_NBITS-2:0], 1'b0};
  end

  assign miso        = out_shreg[`SPI_NBITS-1];
  assign msg.pull_en = cs_fall;
  assign msg.push_en = cs_rise;
  assign msg.push_msg = in_shreg;
  assign payload     = in_shreg[`SPI_NBITS-3:0];
  assign msg.parity  = (^payload) & cs_rise;

  // Master keeps sclk idle while cs is high
  assert property (@(posedge clk) disable iff (reset) (sclk_rise || sclk_fall) |-> !cs_s);

endmodule

// ==== spi_msg_adapter.sv ====
//--------------------------------------------------------------------------
// Buffers between the SPI minion and the host. TX words queue until a pull,
// RX words and parity queue until the host grants credit. Sticky flags
// report pulls from an empty TX FIFO and pushes into a full RX FIFO.
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "spi_cfg.svh"

module spi_msg_adapter (
  input  logic               clk,
  input  logic               reset,
  spi_msg_if.adapter         msg,
  input  logic               tx_valid,
  input  spi_pkg::spi_word_t tx_data,
  output logic               tx_credit,
  output logic               rx_valid,
  output spi_pkg::spi_word_t rx_data,
  output logic               rx_parity,
  input  logic               rx_credit,
  output logic               tx_underflow,
  output logic               rx_overflow
);

  localparam int TX_AW = $clog2(`SPI_TX_DEPTH);
  localparam int RX_AW = $clog2(`SPI_RX_DEPTH);

  //--------------------------------------------------------------------------
  // TX FIFO, host writes, pull reads
  //--------------------------------------------------------------------------
  spi_pkg::spi_word_t   tx_mem [`SPI_TX_DEPTH];
  spi_pkg::spi_tx_ptr_t tx_wr_ptr;
  spi_pkg::spi_tx_ptr_t tx_rd_ptr;
  logic                 tx_empty;
  logic                 tx_full;
  logic                 tx_pop;

  assign tx_empty = (tx_wr_ptr == tx_rd_ptr);
  assign tx_full  = ((tx_wr_ptr - tx_rd_ptr) == spi_pkg::spi_tx_ptr_t'(`SPI_TX_DEPTH));
  assign tx_pop   = msg.pull_en & ~tx_empty;

  // Empty FIFO shifts out zeros
  assign msg.pull_msg = tx_empty ? '0 : tx_mem[tx_rd_ptr[TX_AW-1:0]];

  always_ff @(posedge clk) begin
    if (tx_valid)
      tx_mem[tx_wr_ptr[TX_AW-1:0]] <= tx_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_wr_ptr    <= '0;
      tx_rd_ptr    <= '0;
      tx_credit    <= 1'b0;
      tx_underflow <= 1'b0;
    end else begin
      if (tx_valid)
        tx_wr_ptr <= tx_wr_ptr + 1'b1;
      if (tx_pop)
        tx_rd_ptr <= tx_rd_ptr + 1'b1;
      // Slot freed, hand the credit back
      tx_credit <= tx_pop;
      if (msg.pull_en && tx_empty)
        tx_underflow <= 1'b1;
    end
  end

  //--------------------------------------------------------------------------
  // RX FIFO, push writes, credited reads
  //--------------------------------------------------------------------------
  logic [`SPI_NBITS:0]  rx_mem [`SPI_RX_DEPTH];
  spi_pkg::spi_rx_ptr_t rx_wr_ptr;
  spi_pkg::spi_rx_ptr_t rx_rd_ptr;
  spi_pkg::spi_credit_t rx_credits;
  logic                 rx_empty;
  logic                 rx_full;
  logic                 rx_push;

  assign rx_empty = (rx_wr_ptr == rx_rd_ptr);
  assign rx_full  = ((rx_wr_ptr - rx_rd_ptr) == spi_pkg::spi_rx_ptr_t'(`SPI_RX_DEPTH));
  assign rx_push  = msg.push_en & ~rx_full;

  // One beat per cycle while data and credit are both there
  assign rx_valid = ~rx_empty & (rx_credits != '0);
  assign {rx_parity, rx_data} = rx_mem[rx_rd_ptr[RX_AW-1:0]];

  always_ff @(posedge clk) begin
    if (rx_push)
      rx_mem[rx_wr_ptr[RX_AW-1:0]] <= {msg.parity, msg.push_msg};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_wr_ptr   <= '0;
      rx_rd_ptr   <= '0;
      rx_credits  <= '0;
      rx_overflow <= 1'b0;
    end else begin
      if (rx_push)
        rx_wr_ptr <= rx_wr_ptr + 1'b1;
      if (rx_valid)
        rx_rd_ptr <= rx_rd_ptr + 1'b1;
      if (rx_credit && !rx_valid)
        rx_credits <= rx_credits + 1'b1;
      else if (!rx_credit && rx_valid)
        rx_credits <= rx_credits - 1'b1;
      // Frame is dropped when full
      if (msg.push_en && rx_full)
        rx_overflow <= 1'b1;
    end
  end

  // Host sent without holding a credit
  assert property (@(posedge clk) disable iff (reset) tx_valid |-> !tx_full);

  assert property (@(posedge clk) disable iff (reset)
    !(rx_credit && !rx_valid && (&rx_credits)));

endmodule

// ==== spi_minion_top.sv ====
//--------------------------------------------------------------------------
// Top level of the SPI minion subsystem. Joins the minion and the host
// adapter through the message interface and exposes plain pins and streams.
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module spi_minion_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               cs,
  input  logic               sclk,
  input  logic               mosi,
  output logic               miso,
  input  logic               tx_valid,
  input  spi_pkg::spi_word_t tx_data,
  output logic               tx_credit,
  output logic               rx_valid,
  output spi_pkg::spi_word_t rx_data,
  output logic               rx_parity,
  input  logic               rx_credit,
  output logic               tx_underflow,
  output logic               rx_overflow
);

  spi_msg_if msg_if ();

  // SPI pin side
  spi_minion minion (
    .clk   (clk),
    .reset (reset),
    .cs    (cs),
    .sclk  (sclk),
    .mosi  (mosi),
    .miso  (miso),
    .msg   (msg_if.minion)
  );

  // Host stream side
  spi_msg_adapter adapter (
    .clk          (clk),
    .reset        (reset),
    .msg          (msg_if.adapter),
    .tx_valid     (tx_valid),
    .tx_data      (tx_data),
    .tx_credit    (tx_credit),
    .rx_valid     (rx_valid),
    .rx_data      (rx_data),
    .rx_parity    (rx_parity),
    .rx_credit    (rx_credit),
    .tx_underflow (tx_underflow),
    .rx_overflow  (rx_overflow)
  );

endmodule

// ==== tb_spi_checker.sv ====
//--------------------------------------------------------------------------
// Testbench checker. Watches the top-level pins of the DUT, compares miso
// words and RX beats with expected queues and keeps per-test error counts.
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "spi_cfg.svh"

module tb_spi_checker (
  input logic               clk,
  input logic               cs,
  input logic               sclk,
  input logic               miso,
  input logic               tx_credit,
  input logic               rx_valid,
  input spi_pkg::spi_word_t rx_data,
  input logic               rx_parity,
  input logic               rx_credit,
  input logic               tx_underflow,
  input logic               rx_overflow
);

  spi_pkg::spi_word_t miso_q[$];
  logic [`SPI_NBITS:0] rx_q[$];
  spi_pkg::spi_word_t miso_word;
  int bit_cnt = 0;
  int credits_seen = 0;
  int rx_granted = 0;
  int rx_beats = 0;
  int errors = 0;
  int test_errors = 0;
  int tests_run = 0;

  task automatic expect_miso(input spi_pkg::spi_word_t word);
    miso_q.push_back(word);
  endtask

  task automatic expect_rx(input spi_pkg::spi_word_t word, input logic par);
    rx_q.push_back({par, word});
  endtask

  function automatic int rx_pending();
    return rx_q.size();
  endfunction

  task automatic fail_check(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  // Mode 0, the minion's bit is stable at each sclk rise
  always @(posedge sclk) begin
    if (!cs) begin
      miso_word = {miso_word[`SPI_NBITS-2:0], miso};
      bit_cnt++;
      if (bit_cnt == `SPI_NBITS) begin
        bit_cnt = 0;
        if (miso_q.size() == 0) begin
          $display("Unexpected miso frame %h at %0t", miso_word, $time);
          errors++;
          test_errors++;
        end else if (miso_q[0] != miso_word) begin
          fail_check($sformatf("miso word %h, expected %h", miso_word, miso_q[0]));
          void'(miso_q.pop_front());
        end else begin
          void'(miso_q.pop_front());
        end
      end
    end
  end

  // Host credits, driven on the falling edge
  always @(posedge clk) begin
    if (rx_credit)
      rx_granted++;
  end

  // Outputs settle after the rising edge
  always @(negedge clk) begin
    if (tx_credit)
      credits_seen++;
    if (rx_valid) begin
      if (rx_beats >= rx_granted) begin
        $display("RX beat %h at %0t was sent without a host credit", rx_data, $time);
        errors++;
        test_errors++;
      end
      rx_beats++;
      if (rx_q.size() == 0) begin
        $display("RX beat %h arrived at %0t with no frame expected", rx_data, $time);
        errors++;
        test_errors++;
      end else begin
        if (rx_q[0] != {rx_parity, rx_data})
          fail_check($sformatf("rx beat %h/%b, expected %h/%b", rx_data, rx_parity,
                               rx_q[0][`SPI_NBITS-1:0], rx_q[0][`SPI_NBITS]));
        void'(rx_q.pop_front());
      end
    end
  end

  task automatic check_reset_state();
    if (miso || tx_credit || rx_valid || tx_underflow || rx_overflow)
      fail_check("outputs not idle after reset");
    $display("test reset: %s", (test_errors == 0) ? "ok" : "failed");
    test_errors = 0;
  endtask

  task automatic end_test(input int num, input logic exp_uf, input logic exp_ov,
                          input int exp_credits);
    if (tx_underflow != exp_uf)
      fail_check($sformatf("tx_underflow %b, expected %b", tx_underflow, exp_uf));
    if (rx_overflow != exp_ov)
      fail_check($sformatf("rx_overflow %b, expected %b", rx_overflow, exp_ov));
    if (credits_seen != exp_credits)
      fail_check($sformatf("tx_credit count %0d, expected %0d", credits_seen, exp_credits));
    tests_run++;
    $display("test %0d: %s (%0d errors)", num, (test_errors == 0) ? "ok" : "failed",
             test_errors);
    test_errors = 0;
  endtask

  task automatic report_totals();
    $display("Tests run: %0d, errors: %0d", tests_run, errors);
  endtask

endmodule

// ==== tb_spi_minion.sv ====
//--------------------------------------------------------------------------
// Testbench top for the SPI minion subsystem. Reads frames from the vector
// file, plays SPI master and host, and hands expectations to the checker.
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "spi_cfg.svh"

module tb_spi_minion;

  logic clk = 1'b0;
  logic reset, cs, sclk, mosi, miso;
  logic tx_valid, tx_credit, rx_valid, rx_parity, rx_credit;
  logic tx_underflow, rx_overflow;
  spi_pkg::spi_word_t tx_data, rx_data;

  int v_test[$], v_tx[$], v_mosi[$], v_hold[$], v_miso[$], v_rx[$], v_par[$];
  int seed = 16;
  int tx_sent = 0;
  int tx_returned = 0;

  always #10 clk = ~clk;

  always @(negedge clk)
    if (tx_credit)
      tx_returned++;

  spi_minion_top UUT (
    .clk(clk), .reset(reset), .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso),
    .tx_valid(tx_valid), .tx_data(tx_data), .tx_credit(tx_credit),
    .rx_valid(rx_valid), .rx_data(rx_data), .rx_parity(rx_parity),
    .rx_credit(rx_credit), .tx_underflow(tx_underflow), .rx_overflow(rx_overflow)
  );

  tb_spi_checker chk (
    .clk(clk), .cs(cs), .sclk(sclk), .miso(miso), .tx_credit(tx_credit),
    .rx_valid(rx_valid), .rx_data(rx_data), .rx_parity(rx_parity),
    .rx_credit(rx_credit), .tx_underflow(tx_underflow), .rx_overflow(rx_overflow)
  );

  // "none" becomes -1
  task automatic read_vectors();
    int fd, t, h, p, mo, mi;
    string line, tx_s, rx_s;
    fd = $fopen("spi_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open spi_vectors.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#")
        continue;
      void'($sscanf(line, "%d %s %h %d %h %s %d", t, tx_s, mo, h, mi, rx_s, p));
      v_test.push_back(t);
      v_tx.push_back((tx_s == "none") ? -1 : tx_s.atohex());
      v_rx.push_back((rx_s == "none") ? -1 : rx_s.atohex());
      v_mosi.push_back(mo);
      v_hold.push_back(h);
      v_miso.push_back(mi);
      v_par.push_back(p);
    end
    $fclose(fd);
  endtask

  // Waits for a credit, then one beat
  task automatic send_tx(input int word);
    while (tx_sent - tx_returned >= `SPI_TX_DEPTH)
      @(negedge clk);
    tx_valid = 1'b1;
    tx_data  = spi_pkg::spi_word_t'(word);
    tx_sent++;
    @(negedge clk);
    tx_valid = 1'b0;
  endtask

  // Half periods of 4 clk cycles, mosi set ahead of each rise
  task automatic run_frame(input int word);
    cs = 1'b0;
    for (int b = `SPI_NBITS - 1; b >= 0; b--) begin
      mosi = word[b];
      repeat (4) @(negedge clk);
      sclk = 1'b1;
      repeat (4) @(negedge clk);
      sclk = 1'b0;
    end
    repeat (4) @(negedge clk);
    cs = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic release_credits(input int count);
    repeat (count) begin
      rx_credit = 1'b1;
      @(negedge clk);
      rx_credit = 1'b0;
    end
  endtask

  initial begin
    int prev, pending, exp_credits, gap;
    logic exp_uf, exp_ov;
    reset = 1'b1;
    cs = 1'b1;
    sclk = 1'b0;
    mosi = 1'b0;
    tx_valid = 1'b0;
    tx_data = '0;
    rx_credit = 1'b0;
    prev = -1;
    pending = 0;
    exp_credits = 0;
    exp_uf = 1'b0;
    exp_ov = 1'b0;
    read_vectors();
    fork
      begin
        #(v_test.size() * 20 * 8 * 20 + 20000);
        $display("Timeout: the DUT did not finish the frames in time");
        $display("=== FAIL ===");
        $finish;
      end
    join_none
    repeat (3) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    chk.check_reset_state();
    for (int i = 0; i < v_test.size(); i++) begin
      if (prev >= 0 && v_test[i] != prev)
        chk.end_test(prev, exp_uf, exp_ov, exp_credits);
      prev = v_test[i];
      if (v_tx[i] >= 0) begin
        send_tx(v_tx[i]);
        exp_credits++;
      end else begin
        exp_uf = 1'b1;
      end
      chk.expect_miso(spi_pkg::spi_word_t'(v_miso[i]));
      if (v_rx[i] >= 0) begin
        chk.expect_rx(spi_pkg::spi_word_t'(v_rx[i]), v_par[i][0]);
        pending++;
      end else begin
        exp_ov = 1'b1;
      end
      run_frame(v_mosi[i]);
      if (v_hold[i] == 0) begin
        release_credits(pending);
        pending = 0;
        while (chk.rx_pending() != 0)
          @(negedge clk);
      end
      gap = $random(seed) & 7;
      repeat (gap + 1) @(negedge clk);
    end
    if (prev >= 0)
      chk.end_test(prev, exp_uf, exp_ov, exp_credits);
    chk.report_totals();
    if (chk.errors == 0 && v_test.size() != 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== spi_vectors.txt ====
# test  tx_word  mosi_word  hold_credit  exp_miso  exp_rx  exp_parity
# tx_word or exp_rx "none" means no host word or a dropped RX frame
1 a5 3c 0 a5 3c 0
2 11 81 0 11 81 1
2 22 c3 0 22 c3 0
2 7e 5a 0 7e 5a 1
3 none 0f 0 00 0f 0
3 44 01 0 44 01 1
# credits withheld until the last frame of the test
4 12 10 1 12 10 1
4 34 20 1 34 20 1
4 56 33 0 56 33 0
# five frames into a four-deep RX FIFO, the last one is dropped
5 61 01 1 61 01 1
5 62 02 1 62 02 1
5 63 03 1 63 03 0
5 64 07 1 64 07 1
5 65 0f 0 65 none 0

// ==== filelist.f ====
+incdir+.
spi_pkg.sv
spi_sync.sv
spi_msg_if.sv
spi_minion.sv
spi_msg_adapter.sv
spi_minion_top.sv
tb_spi_checker.sv
tb_spi_minion.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SPI minion testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_spi_minion \
  -f filelist.f \
  -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "=== PASS ===" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
